// File: source/attn_dims_pkg.sv
// Compile-time dimensions of the score stage, nothing is set at run time
// EMBED_DIM must be 2**REDUCE_STAGES and SEQ_LEN must be 2**ROW_W
`default_nettype none

package attn_dims_pkg;

    // Elements per Q, K and V vector
    localparam int EMBED_DIM = 8;

    // Keys scored against one held query
    localparam int SEQ_LEN = 4;

    // Register levels in the adder tree, log2 of EMBED_DIM
    localparam int REDUCE_STAGES = 3;

    // Divide by sqrt(dk) with dk assumed to be 64
    localparam int SCALE_SHIFT = 3;

    // Key position counter width, log2 of SEQ_LEN
    localparam int ROW_W = 2;

endpackage

`default_nettype wire

// File: source/attn_fixed_pkg.sv
// Fixed-point formats of the score path, all two's complement
// Element Q1.7, product Q2.10, sum Q5.10, score Q4.5
`default_nettype none

package attn_fixed_pkg;
    import attn_dims_pkg::*;

    // Integer and fraction bits per format
    localparam int ELEM_I  = 1;
    localparam int ELEM_F  = 7;
    localparam int WPROD_I = 2;
    localparam int WPROD_F = 14;
    localparam int PROD_I  = 2;
    localparam int PROD_F  = 10;
    localparam int DOT_I   = 5;
    localparam int DOT_F   = 10;
    localparam int SCORE_I = 4;
    localparam int SCORE_F = 5;

    typedef logic signed [ELEM_I+ELEM_F-1:0]   elem_t;
    typedef elem_t [EMBED_DIM-1:0]             vec_t;
    typedef logic signed [WPROD_I+WPROD_F-1:0] wide_prod_t;
    typedef logic signed [PROD_I+PROD_F-1:0]   prod_t;
    // Room for EMBED_DIM products without overflow
    typedef logic signed [DOT_I+DOT_F-1:0]     dot_t;
    typedef logic signed [SCORE_I+SCORE_F-1:0] score_t;

    // Output word, one per key
    typedef struct packed {
        score_t           score;
        vec_t             v;
        logic [ROW_W-1:0] row;
        logic             last;
    } score_row_t;

endpackage

`default_nettype wire

// File: source/fixed_saturate.sv
// Signed fixed-point format change, purely combinational
// Needs IN_F >= OUT_F and IN_I >= OUT_I, dropped fraction bits round toward -inf
`timescale 1ns/1ps
`default_nettype none

module fixed_saturate #(
    parameter int IN_I  = 2,
    parameter int IN_F  = 14,
    parameter int OUT_I = 2,
    parameter int OUT_F = 10
) (
    input  wire logic [IN_I+IN_F-1:0]   in,
    output logic      [OUT_I+OUT_F-1:0] out
);

    localparam int IN_W  = IN_I + IN_F;
    localparam int OUT_W = OUT_I + OUT_F;
    // Input integer bits over output fraction bits
    localparam int MID_W = IN_I + OUT_F;
    localparam int DROP  = IN_F - OUT_F;

    logic [MID_W-1:0] mid;
    logic             fits;

    // Plain truncation of a two's complement word is floor
    assign mid = in[IN_W-1:DROP];

    // Fits when the surplus integer bits all copy the sign
    assign fits = (&mid[MID_W-1:OUT_W-1]) | ~(|mid[MID_W-1:OUT_W-1]);

    always_comb begin
        if (fits) begin
            out = mid[OUT_W-1:0];
        end else if (mid[MID_W-1]) begin
            // Most negative code
            out = {1'b1, {(OUT_W-1){1'b0}}};
        end else begin
            // Most positive code
            out = {1'b0, {(OUT_W-1){1'b1}}};
        end
    end

endmodule

`default_nettype wire

// File: source/tree_reduce.sv
// Pipelined binary adder tree, one register level per stage
// All stages share one enable, so a stall at the output freezes the whole tree
`timescale 1ns/1ps
`default_nettype none

module tree_reduce
    import attn_dims_pkg::*;
    import attn_fixed_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire prod_t [EMBED_DIM-1:0] list_in,
    input  wire              vld_in,
    output logic             rdy_out,
    output dot_t             sum,
    output logic             vld_out,
    input  wire              rdy_in
);

    localparam int LAST = REDUCE_STAGES - 1;

    // One valid bit per register level
    logic [REDUCE_STAGES-1:0] stage_vld;
    logic                     en;

    // Advance while the last level is empty or being taken
    assign en      = !stage_vld[LAST] || rdy_in;
    assign rdy_out = en;
    assign vld_out = stage_vld[LAST];

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_vld <= '0;
        end else if (en) begin
            stage_vld[0] <= vld_in;
            for (int s = 1; s < REDUCE_STAGES; s++) begin
                stage_vld[s] <= stage_vld[s-1];
            end
        end
    end

    for (genvar s = 0; s < REDUCE_STAGES; s++) begin : g_stage
        // Level s holds half the nodes of level s-1
        localparam int N = EMBED_DIM >> (s + 1);

        dot_t node [N];

        if (s == 0) begin : g_leaf
            // Pairs of products, sign-extended to the sum width
            always_ff @(posedge clk) begin
                if (en) begin
                    for (int i = 0; i < N; i++) begin
                        node[i] <= dot_t'(list_in[2*i]) + dot_t'(list_in[2*i+1]);
                    end
                end
            end
        end else begin : g_inner
            always_ff @(posedge clk) begin
                if (en) begin
                    for (int i = 0; i < N; i++) begin
                        node[i] <= g_stage[s-1].node[2*i] + g_stage[s-1].node[2*i+1];
                    end
                end
            end
        end
    end

    // Root of the tree
    assign sum = g_stage[LAST].node[0];

endmodule

`default_nettype wire

// File: source/dot_product.sv
// Scaled Q.K score per key, with the key's V carried alongside
// One Q serves SEQ_LEN rows, then a new Q is taken
// Score leaves REDUCE_STAGES enabled edges after the row enters the tree
`timescale 1ns/1ps
`default_nettype none

module dot_product
    import attn_dims_pkg::*;
    import attn_fixed_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire vec_t  q_vec,
    input  wire vec_t  k_vec,
    input  wire vec_t  v_vec,
    input  wire        q_vld,
    input  wire        k_vld,
    input  wire        v_vld,
    output logic       q_rdy,
    output logic       k_rdy,
    output logic       v_rdy,
    output score_t     sc_score,
    output vec_t       sc_v,
    output logic       sc_vld,
    input  wire        sc_rdy
);

    // Capture registers and their full flags
    vec_t             q_reg;
    vec_t             k_reg;
    vec_t             v_reg;
    logic             q_held;
    logic             k_held;
    logic             v_held;
    // Rows still to score with the held Q, zero on the last one
    logic [ROW_W-1:0] rows_left;

    logic             all_held;
    logic             tree_rdy;
    logic             fire;
    logic             last_row;

    wide_prod_t             wide_prod [EMBED_DIM];
    prod_t [EMBED_DIM-1:0]  prods;
    dot_t                   sum;
    dot_t                   scaled_sum;

    // V delay line matched to the tree depth
    vec_t             v_pipe [REDUCE_STAGES];

    assign all_held = q_held && k_held && v_held;
    // Row moves into the tree this cycle
    assign fire     = all_held && tree_rdy;
    assign last_row = (rows_left == '0);

    assign k_rdy = !k_held || fire;
    assign v_rdy = !v_held || fire;
    // Q is only replaced once its final row has gone
    assign q_rdy = !q_held || (fire && last_row);

    always_ff @(posedge clk) begin
        if (rst) begin
            q_held    <= 1'b0;
            rows_left <= '0;
        end else if (q_vld && q_rdy) begin
            q_held    <= 1'b1;
            rows_left <= ROW_W'(SEQ_LEN - 1);
        end else if (fire) begin
            if (last_row) begin
                q_held <= 1'b0;
            end else begin
                rows_left <= rows_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            k_held <= 1'b0;
            v_held <= 1'b0;
        end else begin
            if (k_vld && k_rdy) begin
                k_held <= 1'b1;
            end else if (fire) begin
                k_held <= 1'b0;
            end
            if (v_vld && v_rdy) begin
                v_held <= 1'b1;
            end else if (fire) begin
                v_held <= 1'b0;
            end
        end
    end

    // Payload loads only on a handshake
    always_ff @(posedge clk) begin
        if (q_vld && q_rdy) begin
            q_reg <= q_vec;
        end
        if (k_vld && k_rdy) begin
            k_reg <= k_vec;
        end
        if (v_vld && v_rdy) begin
            v_reg <= v_vec;
        end
    end

    // Q1.7 times Q1.7 gives Q2.14, then floor to Q2.10
    for (genvar i = 0; i < EMBED_DIM; i++) begin : g_mul
        assign wide_prod[i] = q_reg[i] * k_reg[i];

        fixed_saturate #(
            .IN_I  (WPROD_I),
            .IN_F  (WPROD_F),
            .OUT_I (PROD_I),
            .OUT_F (PROD_F)
        ) i_prod_sat (
            .in  (wide_prod[i]),
            .out (prods[i])
        );
    end

    tree_reduce i_tree (
        .clk     (clk),
        .rst     (rst),
        .list_in (prods),
        .vld_in  (all_held),
        .rdy_out (tree_rdy),
        .sum     (sum),
        .vld_out (sc_vld),
        .rdy_in  (sc_rdy)
    );

    // Arithmetic shift keeps the sign
    assign scaled_sum = sum >>> SCALE_SHIFT;

    fixed_saturate #(
        .IN_I  (DOT_I),
        .IN_F  (DOT_F),
        .OUT_I (SCORE_I),
        .OUT_F (SCORE_F)
    ) i_score_sat (
        .in  (scaled_sum),
        .out (sc_score)
    );

    // Steps on the tree enable, so each V stays beside its own sum
    always_ff @(posedge clk) begin
        if (tree_rdy) begin
            v_pipe[0] <= v_reg;
            for (int s = 1; s < REDUCE_STAGES; s++) begin
                v_pipe[s] <= v_pipe[s-1];
            end
        end
    end

    assign sc_v = v_pipe[REDUCE_STAGES-1];

endmodule

`default_nettype wire

// File: source/score_emit.sv
// Output pipe register, full throughput, holds its word under back-pressure
// Key position comes from a local counter that assumes rows leave in order
`timescale 1ns/1ps
`default_nettype none

module score_emit
    import attn_dims_pkg::*;
    import attn_fixed_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire score_t sc_score,
    input  wire vec_t  sc_v,
    input  wire        sc_vld,
    output logic       sc_rdy,
    output score_row_t out,
    output logic       out_vld,
    input  wire        out_rdy
);

    score_t           score_q;
    vec_t             v_q;
    logic [ROW_W-1:0] row_cnt;

    // Load when empty or when the held word leaves this cycle
    assign sc_rdy = !out_vld || out_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_vld <= 1'b0;
        end else if (sc_rdy) begin
            out_vld <= sc_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (sc_rdy && sc_vld) begin
            score_q <= sc_score;
            v_q     <= sc_v;
        end
    end

    // Position of the word at the output, steps per accepted word
    always_ff @(posedge clk) begin
        if (rst) begin
            row_cnt <= '0;
        end else if (out_vld && out_rdy) begin
            if (row_cnt == ROW_W'(SEQ_LEN - 1)) begin
                row_cnt <= '0;
            end else begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        out.score = score_q;
        out.v     = v_q;
        out.row   = row_cnt;
        out.last  = (row_cnt == ROW_W'(SEQ_LEN - 1));
    end

endmodule

`default_nettype wire

// File: source/attn_score_top.sv
// Score stage top, valid/ready on every stream
// Q is held for SEQ_LEN key/value pairs
`timescale 1ns/1ps
`default_nettype none

module attn_score_top
    import attn_fixed_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire vec_t   q_vec,
    input  wire         q_vld,
    output logic        q_rdy,
    input  wire vec_t   k_vec,
    input  wire         k_vld,
    output logic        k_rdy,
    input  wire vec_t   v_vec,
    input  wire         v_vld,
    output logic        v_rdy,
    output score_row_t  out,
    output logic        out_vld,
    input  wire         out_rdy
);

    // Score and value between the stages
    score_t sc_score;
    vec_t   sc_v;
    logic   sc_vld;
    logic   sc_rdy;

    dot_product i_dot (
        .clk      (clk),
        .rst      (rst),
        .q_vec    (q_vec),
        .k_vec    (k_vec),
        .v_vec    (v_vec),
        .q_vld    (q_vld),
        .k_vld    (k_vld),
        .v_vld    (v_vld),
        .q_rdy    (q_rdy),
        .k_rdy    (k_rdy),
        .v_rdy    (v_rdy),
        .sc_score (sc_score),
        .sc_v     (sc_v),
        .sc_vld   (sc_vld),
        .sc_rdy   (sc_rdy)
    );

    score_emit i_emit (
        .clk      (clk),
        .rst      (rst),
        .sc_score (sc_score),
        .sc_v     (sc_v),
        .sc_vld   (sc_vld),
        .sc_rdy   (sc_rdy),
        .out      (out),
        .out_vld  (out_vld),
        .out_rdy  (out_rdy)
    );

endmodule

`default_nettype wire

// File: tb/attn_score_chk.sv
// Handshake and tagging assertions, bound into attn_score_top
// Flags stay set after a failure so the testbench can see them
`timescale 1ns/1ps
`default_nettype none

module attn_score_chk
    import attn_dims_pkg::*;
    import attn_fixed_pkg::*;
(
    input wire             clk,
    input wire             rst,
    input wire             q_vld,
    input wire             q_rdy,
    input wire             k_vld,
    input wire             k_rdy,
    input wire score_row_t out,
    input wire             out_vld,
    input wire             out_rdy
);

    // Accepted queries and keys since reset
    int   q_cnt;
    int   k_cnt;

    // One sticky flag per assertion
    bit   reset_bad = 1'b0;
    bit   stall_bad = 1'b0;
    bit   q_rdy_bad = 1'b0;
    bit   row_bad   = 1'b0;
    logic any_fail;

    assign any_fail = reset_bad | stall_bad | q_rdy_bad | row_bad;

    always_ff @(posedge clk) begin
        if (rst) begin
            q_cnt <= 0;
            k_cnt <= 0;
        end else begin
            if (q_vld && q_rdy) begin
                q_cnt <= q_cnt + 1;
            end
            if (k_vld && k_rdy) begin
                k_cnt <= k_cnt + 1;
            end
        end
    end

    // Output register comes up empty
    reset_empty: assert property (@(posedge clk) $past(rst) && !rst |-> !out_vld)
        else begin
            $error("out_vld high on the first cycle after reset");
            reset_bad = 1'b1;
        end

    // Stalled word must not change
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_vld && !out_rdy |=> out_vld && $stable(out))
        else begin
            $error("output word changed or dropped while stalled");
            stall_bad = 1'b1;
        end

    // New Q only after every row of the held one has its key
    q_reuse: assert property (@(posedge clk) disable iff (rst)
        q_rdy |-> (k_cnt >= q_cnt * SEQ_LEN))
        else begin
            $error("q_rdy high while the held query still has rows left");
            q_rdy_bad = 1'b1;
        end

    // Key position steps by one inside a sequence
    row_step: assert property (@(posedge clk) disable iff (rst)
        out_vld && out_rdy && !out.last |=> out.row == ROW_W'($past(out.row) + 1'b1))
        else begin
            $error("key position did not step after an accepted row");
            row_bad = 1'b1;
        end

endmodule

`default_nettype wire

// File: tb/attn_score_tb.sv
// Testbench for attn_score_top with seeded $urandom stimulus
// Expected words come from an integer model of the fixed-point rules
`timescale 1ns/1ps
`default_nettype none

module attn_score_tb
    import attn_dims_pkg::*;
    import attn_fixed_pkg::*;
();

    localparam int          CLK_PERIOD = 20;
    localparam int unsigned SEED       = 32'h6e344d26;
    // Queries per phase
    localparam int          RAND_Q     = 6;
    localparam int          STALL_Q    = 6;
    localparam int          EXT_Q      = 2;
    localparam int          TOTAL_ROWS = (RAND_Q + STALL_Q + EXT_Q) * SEQ_LEN;
    // Watchdog allowance in cycles per row
    localparam int          ROW_BUDGET = 200;

    logic       clk;
    logic       rst;
    vec_t       q_vec;
    vec_t       k_vec;
    vec_t       v_vec;
    logic       q_vld;
    logic       k_vld;
    logic       v_vld;
    logic       q_rdy;
    logic       k_rdy;
    logic       v_rdy;
    score_row_t out;
    logic       out_vld;
    logic       out_rdy;

    // Stimulus and expected words of the running phase
    vec_t       q_list [$];
    vec_t       k_list [$];
    vec_t       v_list [$];
    score_row_t exp_q  [$];
    string      test_name;
    bit         stall_mode;
    // Output words accepted since reset
    int         out_cnt = 0;

    attn_score_top i_attn_score_top (
        .clk     (clk),
        .rst     (rst),
        .q_vec   (q_vec),
        .q_vld   (q_vld),
        .q_rdy   (q_rdy),
        .k_vec   (k_vec),
        .k_vld   (k_vld),
        .k_rdy   (k_rdy),
        .v_vec   (v_vec),
        .v_vld   (v_vld),
        .v_rdy   (v_rdy),
        .out     (out),
        .out_vld (out_vld),
        .out_rdy (out_rdy)
    );

    bind attn_score_top attn_score_chk i_chk (
        .clk     (clk),
        .rst     (rst),
        .q_vld   (q_vld),
        .q_rdy   (q_rdy),
        .k_vld   (k_vld),
        .k_rdy   (k_rdy),
        .out     (out),
        .out_vld (out_vld),
        .out_rdy (out_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare(input string field, input longint exp_val, input longint act_val);
        assert (exp_val == act_val) else begin
            $display("mismatch %s %s: expected %0d actual %0d",
                     test_name, field, exp_val, act_val);
            stop_on_error();
        end
    endtask

    // Floor each product to Q2.10, sum, scale, floor to Q4.5, clamp
    function automatic score_t model_score(input vec_t q, input vec_t k);
        int acc;
        int prod;
        acc = 0;
        for (int i = 0; i < EMBED_DIM; i++) begin
            prod = int'($signed(q[i])) * int'($signed(k[i]));
            acc += prod >>> 4;
        end
        acc = (acc >>> SCALE_SHIFT) >>> 5;
        if (acc > 255) begin
            acc = 255;
        end
        if (acc < -256) begin
            acc = -256;
        end
        return score_t'(acc);
    endfunction

    function automatic vec_t rand_vec();
        return {$urandom(), $urandom()};
    endfunction

    function automatic void put_stream(input int which, input vec_t item, input logic vld);
        case (which)
            0: begin
                q_vec = item;
                q_vld = vld;
            end
            1: begin
                k_vec = item;
                k_vld = vld;
            end
            default: begin
                v_vec = item;
                v_vld = vld;
            end
        endcase
    endfunction

    function automatic logic stream_rdy(input int which);
        case (which)
            0:       return q_rdy;
            1:       return k_rdy;
            default: return v_rdy;
        endcase
    endfunction

    task automatic build_phase(input int n_q, input bit extremes);
        vec_t       q;
        vec_t       k;
        score_row_t e;
        q_list.delete();
        k_list.delete();
        v_list.delete();
        for (int n = 0; n < n_q; n++) begin
            // Most negative Q against -128 keys first and +127 keys next
            q = extremes ? {EMBED_DIM{8'h80}} : rand_vec();
            q_list.push_back(q);
            for (int j = 0; j < SEQ_LEN; j++) begin
                k = rand_vec();
                if (extremes) begin
                    k = (n == 0) ? {EMBED_DIM{8'h80}} : {EMBED_DIM{8'h7f}};
                end
                e.v     = rand_vec();
                e.score = model_score(q, k);
                e.row   = ROW_W'(j);
                e.last  = (j == SEQ_LEN - 1);
                k_list.push_back(k);
                v_list.push_back(e.v);
                exp_q.push_back(e);
            end
        end
    endtask

    // One stream with random valid gaps and data held until taken
    task automatic send_stream(input int which);
        int   n;
        vec_t item;
        n = (which == 0) ? q_list.size() : k_list.size();
        for (int i = 0; i < n; i++) begin
            case (which)
                0:       item = q_list[i];
                1:       item = k_list[i];
                default: item = v_list[i];
            endcase
            repeat ($urandom_range(0, 2)) @(negedge clk);
            put_stream(which, item, 1'b1);
            // Ready is settled just after the falling edge
            #1;
            while (!stream_rdy(which)) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
            put_stream(which, item, 1'b0);
        end
    endtask

    task automatic collect(input int n_rows);
        score_row_t e;
        int         got;
        got = 0;
        while (got < n_rows) begin
            @(negedge clk);
            out_rdy = stall_mode ? 1'($urandom_range(0, 1)) : 1'b1;
            #1;
            if (out_vld && out_rdy) begin
                e = exp_q.pop_front();
                compare("score", longint'(e.score), longint'(out.score));
                compare("value", longint'(e.v), longint'(out.v));
                compare("row", longint'(e.row), longint'(out.row));
                compare("last", longint'(e.last), longint'(out.last));
                got++;
            end
        end
        @(negedge clk);
        out_rdy = 1'b1;
    endtask

    // Nothing may follow the last expected row
    task automatic expect_idle();
        repeat (REDUCE_STAGES + 2) begin
            @(negedge clk);
            #1;
            if (out_vld) begin
                $display("extra output word after the %s phase", test_name);
                stop_on_error();
            end
        end
    endtask

    task automatic run_phase(input string name, input int n_q, input bit extremes,
                             input bit stall);
        test_name  = name;
        stall_mode = stall;
        build_phase(n_q, extremes);
        @(negedge clk);
        fork
            send_stream(0);
            send_stream(1);
            send_stream(2);
            collect(n_q * SEQ_LEN);
        join
        expect_idle();
    endtask

    // Transfers seen at the edge, whether or not a phase is collecting
    always @(posedge clk) begin
        if (!rst && out_vld && out_rdy) begin
            out_cnt++;
        end
    end

    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        q_vec      = '0;
        k_vec      = '0;
        v_vec      = '0;
        q_vld      = 1'b0;
        k_vld      = 1'b0;
        v_vld      = 1'b0;
        out_rdy    = 1'b1;
        stall_mode = 1'b0;
        test_name  = "reset";
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        // Empty capture registers take input at once
        compare("ready", longint'(3'b111), longint'({q_rdy, k_rdy, v_rdy}));

        run_phase("random", RAND_Q, 1'b0, 1'b0);
        run_phase("backpressure", STALL_Q, 1'b0, 1'b1);
        run_phase("extremes", EXT_Q, 1'b1, 1'b0);

        // One output word per row sent over all phases
        test_name = "count";
        if (out_cnt != TOTAL_ROWS) begin
            $display("mismatch %s: expected %0d actual %0d", test_name, TOTAL_ROWS, out_cnt);
            stop_on_error();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    // Stop at the first bound assertion failure
    initial begin
        wait (i_attn_score_top.i_chk.any_fail);
        $display("bound assertion failed in phase %s", test_name);
        stop_on_error();
    end

    initial begin
        #(TOTAL_ROWS * ROW_BUDGET * CLK_PERIOD);
        $display("timeout in phase %s, rows still missing", test_name);
        stop_on_error();
    end

endmodule

`default_nettype wire

// File: build.f
source/attn_dims_pkg.sv
source/attn_fixed_pkg.sv
source/fixed_saturate.sv
source/tree_reduce.sv
source/dot_product.sv
source/score_emit.sv
source/attn_score_top.sv
tb/attn_score_chk.sv
tb/attn_score_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the score stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f build.f --top-module attn_score_tb -o attn_score_sim

# Raise the error limit so the testbench can report checker failures itself
./obj_dir/attn_score_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
else
    exit 1
fi
